/* build.f */
+incdir+src
src/snn_pkg.sv
src/network_dispatch.sv
src/lif_network.sv
src/network_sink.sv
src/snn_top.sv
testbench/snn_checker.sv
testbench/tb_snn_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds with Verilator, runs the testbench and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_snn_top -f build.f -o sim_snn \
    && ./obj_dir/sim_snn > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -qx "TB PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* src/lif_network.sv */
//////////////////////////////////////////////////
// fixed unit weights and no leak
// fire is combinational and valid only during en
//////////////////////////////////////////////////

`include "snn_macros.svh"

module lif_network import snn_pkg::*; (
    input  logic                    clk,
    input  logic                    arstn,
    input  net_bus_t                net,
    output logic [`SNN_NUM_OUT-1:0] fire
);

    localparam int POT_W = `SNN_POT_WIDTH;

    for (genvar j = 0; j < `SNN_NUM_OUT; j++) begin : g_neuron
        logic [POT_W-1:0] pot;
        logic [POT_W-1:0] sum;

        // neuron j listens to input j and its upper neighbour
        assign sum = pot
                   + POT_W'(net.inp[j % `SNN_NUM_INP])
                   + POT_W'(net.inp[(j + 1) % `SNN_NUM_INP]);

        assign fire[j] = net.en && (sum >= POT_W'(`SNN_THRESH));

        always_ff @(posedge clk or negedge arstn) begin
            if (!arstn) begin
                pot <= '0;
            end else if (net.clr) begin
                pot <= '0;
            end else if (net.en) begin
                // a firing neuron starts over from rest
                pot <= fire[j] ? '0 : sum;
            end
        end

        // a stored potential is always below threshold after a tick
        assert property (@(posedge clk) disable iff (!arstn)
            pot <= POT_W'(`SNN_THRESH));
    end

endmodule

/* src/network_dispatch.sv */
//////////////////////////////////////////////////
// in_ready stays low while a RUN, CLR or SNC is issued
//////////////////////////////////////////////////

`include "snn_macros.svh"

module network_dispatch import snn_pkg::*; (
    input  logic     clk,
    input  logic     arstn,
    input  packet_t  in_pkt,
    input  logic     in_valid,
    output logic     in_ready,
    input  logic     net_ready,
    output net_bus_t net
);

    typedef enum logic [1:0] {D_IDLE, D_TICK, D_CLR, D_SNC} dstate_t;

    dstate_t                   state;
    logic [`SNN_PKT_WIDTH-3:0] run_left;
    logic [`SNN_NUM_INP-1:0]   pend;
    logic                      accept;

    assign in_ready = (state == D_IDLE);
    assign accept   = in_valid && in_ready;

    // strobes only go out while the sink can take them
    always_comb begin
        net      = '0;
        net.en   = (state == D_TICK) && net_ready;
        net.clr  = (state == D_CLR) && net_ready;
        net.sync = (state == D_SNC) && net_ready;
        net.inp  = net.en ? pend : '0;
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state    <= D_IDLE;
            run_left <= '0;
            pend     <= '0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (accept) begin
                        case (in_pkt.op)
                            RUN: begin
                                // a RUN of zero ticks is simply dropped
                                if (in_pkt.pl.run_len != '0) begin
                                    run_left <= in_pkt.pl.run_len;
                                    state    <= D_TICK;
                                end
                            end
                            CLR: state <= D_CLR;
                            SPK: pend[in_pkt.pl.spk.idx] <= 1'b1;
                            SNC: state <= D_SNC;
                        endcase
                    end
                end
                D_TICK: begin
                    if (net_ready) begin
                        // pending spikes ride on the first tick only
                        pend     <= '0;
                        run_left <= run_left - 1'b1;
                        if (run_left == 1)
                            state <= D_IDLE;
                    end
                end
                D_CLR, D_SNC: begin
                    if (net_ready)
                        state <= D_IDLE;
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    // at most one network command per cycle
    assert property (@(posedge clk) disable iff (!arstn)
        $onehot0({net.en, net.clr, net.sync}));

endmodule

/* src/network_sink.sv */
//////////////////////////////////////////////////
// net_ready is high only in IDLE with room in the run counter
// SPK packets leave in ascending neuron order
//////////////////////////////////////////////////

`include "snn_macros.svh"

module network_sink import snn_pkg::*; (
    input  logic                    clk,
    input  logic                    arstn,
    input  net_bus_t                net,
    input  logic [`SNN_NUM_OUT-1:0] fire,
    output logic                    net_ready,
    output packet_t                 out_pkt,
    output logic                    out_valid,
    input  logic                    out_ready
);

    localparam int NUM_OUT = `SNN_NUM_OUT;

    typedef enum logic [2:0] {IDLE, RUNS, CLRD, SPKS, SYNC} state_t;

    state_t                          state, next_state;
    logic [`SNN_PKT_WIDTH-3:0]       run_cnt;
    logic                            run_full;
    logic [NUM_OUT-1:0]              fires_l;
    logic [NUM_OUT-1:0]              fires_left;
    logic [NUM_OUT-1:0]              evt_fire;
    logic [$clog2(NUM_OUT)-1:0]      spk_idx;
    logic                            spk_hit;
    logic                            clr_l;
    logic                            sync_l;
    logic                            evt;

    // first output stage still owed after a flush
    function automatic state_t pick_next(input logic clr, input logic [NUM_OUT-1:0] fires,
                                         input logic sync);
        state_t s;
        s = IDLE;
        if (sync)
            s = SYNC;
        if (|fires)
            s = SPKS;
        if (clr)
            s = CLRD;
        return s;
    endfunction

    assign run_full   = &run_cnt;
    assign net_ready  = (state == IDLE) && !run_full;
    assign evt_fire   = net.en ? fire : '0;
    assign evt        = net.clr || net.sync || (|evt_fire);
    assign spk_hit    = fires_l[spk_idx];
    assign fires_left = fires_l & ~(NUM_OUT'(1) << spk_idx);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // a pending run always goes out before anything else
                if (run_full || (evt && run_cnt != '0))
                    next_state = RUNS;
                else if (evt)
                    next_state = pick_next(net.clr, evt_fire, net.sync);
            end
            RUNS: begin
                if (out_ready)
                    next_state = pick_next(clr_l, fires_l, sync_l);
            end
            CLRD: begin
                if (out_ready)
                    next_state = pick_next(1'b0, fires_l, sync_l);
            end
            SPKS: begin
                if (spk_hit && out_ready && fires_left == '0)
                    next_state = pick_next(1'b0, '0, sync_l);
            end
            SYNC: begin
                if (out_ready)
                    next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state   <= IDLE;
            run_cnt <= '0;
            fires_l <= '0;
            clr_l   <= 1'b0;
            sync_l  <= 1'b0;
            spk_idx <= '0;
        end else begin
            state <= next_state;
            case (state)
                IDLE: begin
                    fires_l <= evt_fire;
                    clr_l   <= net.clr;
                    sync_l  <= net.sync;
                    spk_idx <= '0;
                    // the firing tick itself is implied by its SPK packets
                    if (net.en && !(|fire))
                        run_cnt <= run_cnt + 1'b1;
                end
                RUNS: begin
                    if (out_ready)
                        run_cnt <= '0;
                end
                SPKS: begin
                    // silent neurons are stepped over one per cycle
                    if (!spk_hit || out_ready) begin
                        spk_idx <= spk_idx + 1'b1;
                        fires_l <= fires_left;
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        out_pkt   = '0;
        out_valid = 1'b0;
        case (state)
            RUNS: begin
                out_pkt.op         = RUN;
                out_pkt.pl.run_len = run_cnt;
                out_valid          = 1'b1;
            end
            CLRD: begin
                out_pkt.op = CLR;
                out_valid  = 1'b1;
            end
            SPKS: begin
                out_pkt.op         = SPK;
                out_pkt.pl.spk.idx = spk_idx;
                out_valid          = spk_hit;
            end
            SYNC: begin
                out_pkt.op = SNC;
                out_valid  = 1'b1;
            end
            default: ;
        endcase
    end

    // a stalled word is held unchanged until it transfers
    assert property (@(posedge clk) disable iff (!arstn)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_pkt)));

endmodule

/* src/snn_macros.svh */
//////////////////////////////////////////////////
// sizes of the packet stream and the neuron layer
// SNN_NUM_OUT must be a power of two for the SPK index
//////////////////////////////////////////////////

`ifndef SNN_MACROS_SVH
`define SNN_MACROS_SVH

// one packet word is a 2-bit opcode plus the payload
`define SNN_PKT_WIDTH 16

// network input lines that SPK addresses on the input side
`define SNN_NUM_INP 4

// output neurons with one SPK packet each
`define SNN_NUM_OUT 4

// potential at which a neuron fires
`define SNN_THRESH 3

// must hold SNN_THRESH plus two input spikes
`define SNN_POT_WIDTH 4

`endif

/* src/snn_pkg.sv */
//////////////////////////////////////////////////
// packet and bus types shared by every block
//////////////////////////////////////////////////

`include "snn_macros.svh"

package snn_pkg;

    // packet prefix with the same encoding on both sides
    typedef enum logic [1:0] {RUN, CLR, SPK, SNC} opcode_t;

    // SPK payload carries only a neuron or input index in the low bits
    typedef struct packed {
        logic [`SNN_PKT_WIDTH-3-$clog2(`SNN_NUM_OUT):0] rsvd;
        logic [$clog2(`SNN_NUM_OUT)-1:0]                idx;
    } spk_payload_t;

    typedef union packed {
        logic [`SNN_PKT_WIDTH-3:0] run_len;
        spk_payload_t              spk;
    } payload_u;

    typedef struct packed {
        opcode_t  op;
        payload_u pl;
    } packet_t;

    // en, clr and sync are single-cycle strobes
    typedef struct packed {
        logic                    en;
        logic                    clr;
        logic                    sync;
        logic [`SNN_NUM_INP-1:0] inp;
    } net_bus_t;

endpackage

/* src/snn_top.sv */
//////////////////////////////////////////////////
// packets in and out with valid/ready on both sides
//////////////////////////////////////////////////

`include "snn_macros.svh"

module snn_top import snn_pkg::*; (
    input  logic    clk,
    input  logic    arstn,
    input  packet_t in_pkt,
    input  logic    in_valid,
    output logic    in_ready,
    output packet_t out_pkt,
    output logic    out_valid,
    input  logic    out_ready
);

    net_bus_t                net;
    logic                    net_ready;
    logic [`SNN_NUM_OUT-1:0] fire;

    network_dispatch i_dispatch (
        .clk       (clk),
        .arstn     (arstn),
        .in_pkt    (in_pkt),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .net_ready (net_ready),
        .net       (net)
    );

    lif_network i_network (
        .clk   (clk),
        .arstn (arstn),
        .net   (net),
        .fire  (fire)
    );

    network_sink i_sink (
        .clk       (clk),
        .arstn     (arstn),
        .net       (net),
        .fire      (fire),
        .net_ready (net_ready),
        .out_pkt   (out_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

/* testbench/snn_checker.sv */
//////////////////////////////////////////////////
// the expected table is seen twice and the replay counts as one test
//////////////////////////////////////////////////

module snn_checker import snn_pkg::*; #(
    parameter int N_EXP = 1
) (
    input  logic    clk,
    input  logic    arstn,
    input  packet_t out_pkt,
    input  logic    out_valid,
    input  logic    out_ready,
    input  packet_t exp_pkt [N_EXP],
    input  int      exp_tid [N_EXP],
    input  logic    done,
    output int      n_rx,
    output int      n_err
);

    int   e;
    int   tid;
    int   test_err;
    int   tests_ok;
    int   tests_run;
    logic reported;

    always @(posedge clk) begin
        if (!arstn) begin
            n_rx      = 0;
            n_err     = 0;
            test_err  = 0;
            tests_ok  = 0;
            tests_run = 0;
            reported  = 1'b0;
        end else if (out_valid && out_ready) begin
            e   = n_rx % N_EXP;
            tid = (n_rx < N_EXP) ? exp_tid[e] : exp_tid[N_EXP-1] + 1;
            if (n_rx >= 2 * N_EXP) begin
                $display("extra packet %s %0d left the DUT after the expected sequence, at %0t",
                         out_pkt.op.name(), out_pkt.pl.run_len, $time);
                n_err++;
            end else if (out_pkt !== exp_pkt[e]) begin
                $display("ERROR t=%0t out_pkt: got %s %0d, expected %s %0d", $time,
                         out_pkt.op.name(), out_pkt.pl.run_len,
                         exp_pkt[e].op.name(), exp_pkt[e].pl.run_len);
                n_err++;
                test_err++;
            end
            // a test ends on its last table row and the replay only at the very end
            if (n_rx == N_EXP - 1 || n_rx == 2 * N_EXP - 1 ||
                (n_rx < N_EXP - 1 && exp_tid[e + 1] != tid)) begin
                tests_run++;
                if (test_err == 0)
                    tests_ok++;
                $display("test %0d finished: %0d mismatched packets", tid, test_err);
                test_err = 0;
            end
            n_rx++;
        end
        if (done && !reported) begin
            $display("summary: %0d of %0d tests clean, %0d packets seen, %0d errors",
                     tests_ok, tests_run, n_rx, n_err);
            reported = 1'b1;
        end
    end

endmodule

/* testbench/tb_snn_top.sv */
//////////////////////////////////////////////////
// the stimulus table runs twice and the second pass has random out_ready
// both passes must give the same hand-derived packet sequence
//////////////////////////////////////////////////

`include "snn_macros.svh"

module tb_snn_top import snn_pkg::*; ();

    localparam int N_STIM = 27;
    localparam int N_EXP  = 15;
    localparam int PASSES = 2;

    logic        clk       = 1'b0;
    logic        out_ready = 1'b0;
    logic [16:0] lfsr      = 17'd92501;
    int          cycles    = 0;
    int          limit     = 0;
    logic        arstn;
    logic        in_valid;
    logic        in_ready;
    logic        out_valid;
    logic        bp_on;
    logic        done;
    packet_t     in_pkt;
    packet_t     out_pkt;
    int          n_rx;
    int          n_err;
    packet_t     stim_pkt [N_STIM];
    packet_t     exp_pkt [N_EXP];
    int          exp_tid [N_EXP];

    function automatic packet_t pkt(input opcode_t op, input int v);
        packet_t p;
        p.op         = op;
        p.pl.run_len = v[`SNN_PKT_WIDTH-3:0];
        return p;
    endfunction

    // Fibonacci form of x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic send_pkt(input packet_t p);
        @(posedge clk);
        in_pkt   <= p;
        in_valid <= 1'b1;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    always #50 clk = ~clk;

    snn_top i_snn_top (
        .clk       (clk),
        .arstn     (arstn),
        .in_pkt    (in_pkt),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_pkt   (out_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    snn_checker #(.N_EXP(N_EXP)) i_checker (
        .clk       (clk),
        .arstn     (arstn),
        .out_pkt   (out_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .exp_pkt   (exp_pkt),
        .exp_tid   (exp_tid),
        .done      (done),
        .n_rx      (n_rx),
        .n_err     (n_err)
    );

    // one LFSR step per out_ready bit
    always @(posedge clk) begin
        if (bp_on) begin
            lfsr = lfsr_step(lfsr);
            out_ready <= lfsr[0];
        end else begin
            out_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: %0d of %0d expected packets seen after %0d cycles",
                     n_rx, PASSES * N_EXP, limit);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int runs;
        arstn    = 1'b0;
        in_pkt   = '0;
        in_valid = 1'b0;
        bp_on    = 1'b0;
        done     = 1'b0;
        runs     = 0;
        stim_pkt = '{
            // test 1 brings n0 to 2 on the first tick and input 0 tips it over on the third
            pkt(SPK, 0), pkt(SPK, 1), pkt(RUN, 2), pkt(SPK, 0), pkt(RUN, 1),
            // test 2 holds ten silent ticks back until the sync
            pkt(RUN, 10), pkt(SNC, 0),
            // test 3 leaves n1 at 2 before the clear and then input 1 needs three ticks
            pkt(SPK, 2), pkt(RUN, 1), pkt(CLR, 0),
            pkt(SPK, 1), pkt(RUN, 1), pkt(SPK, 1), pkt(RUN, 1), pkt(SPK, 1), pkt(RUN, 1),
            // test 4 sends all inputs twice so every neuron goes 2 then 4 and fires
            pkt(SPK, 0), pkt(SPK, 1), pkt(SPK, 2), pkt(SPK, 3), pkt(RUN, 1),
            pkt(SPK, 0), pkt(SPK, 1), pkt(SPK, 2), pkt(SPK, 3), pkt(RUN, 1),
            pkt(SNC, 0)
        };
        exp_pkt = '{
            pkt(RUN, 2), pkt(SPK, 0),
            pkt(RUN, 10), pkt(SNC, 0),
            pkt(RUN, 1), pkt(CLR, 0), pkt(RUN, 2), pkt(SPK, 0), pkt(SPK, 1),
            pkt(RUN, 1), pkt(SPK, 0), pkt(SPK, 1), pkt(SPK, 2), pkt(SPK, 3), pkt(SNC, 0)
        };
        exp_tid = '{1, 1, 2, 2, 3, 3, 3, 3, 3, 4, 4, 4, 4, 4, 4};
        foreach (stim_pkt[i])
            if (stim_pkt[i].op == RUN)
                runs += int'(stim_pkt[i].pl.run_len);
        limit = 40 * PASSES * (N_STIM + runs);

        repeat (4) @(posedge clk);
        arstn <= 1'b1;
        // the table leaves every potential at rest, so the replay starts clean
        for (int pass = 0; pass < PASSES; pass++) begin
            @(posedge clk);
            bp_on <= (pass != 0);
            foreach (stim_pkt[i])
                send_pkt(stim_pkt[i]);
        end
        while (n_rx < PASSES * N_EXP)
            @(negedge clk);
        // a stray packet beyond the table would show up here
        repeat (20) @(negedge clk);
        @(posedge clk);
        done <= 1'b1;
        repeat (2) @(negedge clk);
        if (n_err == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
